// File: rv_core_top.f
hdl/rv_pkg.sv
hdl/pipe_reg.sv
hdl/if_stage.sv
hdl/id_stage.sv
hdl/ex_stage.sv
hdl/mem_stage.sv
hdl/wb_stage.sv
hdl/rv_core_top.sv
verification/tb_rv_core_top.sv

// File: verification/core_vectors.txt
# P <byte address hex> <instruction word hex>
# E <test name> <pc hex> <rd decimal> <expected rd value hex, ignored when rd is 0>
P 00 00500093
P 04 ffd08113
P 08 123451b7
P 0c 00208233
P 10 401102b3
P 14 00527333
P 18 003363b3
P 1c 0043c433
P 20 0012a4b3
P 24 00803823
P 28 01003503
P 2c 001505b3
P 30 00708013
P 34 00100633
P 38 00208463
P 3c 00209463
P 40 06300693
P 44 00160463
P 48 06200693
P 4c 0080076f
P 50 06100693
P 54 00100073
E addi_x1 00 1 5
E addi_fwd_dist1 04 2 2
E lui_x3 08 3 12345000
E add_fwd_dist2_dist3 0c 4 7
E sub_negative 10 5 fffffffffffffffd
E and_x6 14 6 5
E or_x7 18 7 12345005
E xor_x8 1c 8 12345002
E slt_signed 20 9 1
E sd_x8 24 0 0
E ld_after_sd 28 10 12345002
E add_load_use 2c 11 12345007
E addi_to_x0 30 0 0
E add_reads_x0 34 12 5
E beq_not_taken 38 0 0
E bne_taken 3c 0 0
E beq_taken 44 0 0
E jal_link 4c 14 50
E ebreak_halt 54 0 0

// File: verification/tb_rv_core_top.sv
// run from the project root; rom and data memory hold 64 entries each from address 0
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core_top;

    localparam int MAX_ENTRIES  = 64;
    localparam int RESET_CYCLES = 8;
    localparam int HALT_CYCLES  = 20;   // quiet window checked after halt

    logic        clk = 1'b0;
    logic        arst_n = 1'b1;
    wire  [63:0] inst_addr;
    wire  [31:0] inst;
    wire         awvalid;
    wire  [63:0] awaddr;
    logic        awready = 1'b0;
    wire         wvalid;
    wire  [63:0] wdata;
    wire  [7:0]  wstrb;
    logic        wready = 1'b0;
    logic        bvalid = 1'b0;
    wire         bready;
    wire         arvalid;
    wire  [63:0] araddr;
    logic        arready = 1'b0;
    logic        rvalid = 1'b0;
    logic [63:0] rdata = '0;
    wire         rready;
    wire         retire_valid;
    wire  [63:0] retire_pc;
    wire  [4:0]  retire_rd;
    wire  [63:0] retire_wdata;
    wire         halt;

    logic [31:0]     rom [0:63];
    logic [63:0]     dmem [0:63];
    logic [8*24-1:0] exp_name [0:MAX_ENTRIES-1];
    logic [63:0]     exp_pc [0:MAX_ENTRIES-1];
    logic [4:0]      exp_rd [0:MAX_ENTRIES-1];
    logic [63:0]     exp_value [0:MAX_ENTRIES-1];
    int              exp_count = 0;
    int              retire_count = 0;
    logic            vectors_loaded = 1'b0;
    int              seed;

    logic            aw_got = 1'b0;
    logic            w_got = 1'b0;
    logic            ar_got = 1'b0;
    logic [63:0]     aw_addr_q;
    logic [63:0]     w_data_q;
    logic [63:0]     ar_addr_q;
    int              aw_wait = 0;
    int              w_wait = 0;
    int              ar_wait = 0;
    int              b_wait = 0;
    int              r_wait = 0;

    rv_core_top #(.RESET_PC(64'h0)) i_dut (
        .clk_i(clk), .arst_n_i(arst_n),
        .inst_addr_o(inst_addr), .inst_i(inst),
        .awvalid_o(awvalid), .awaddr_o(awaddr), .awready_i(awready),
        .wvalid_o(wvalid), .wdata_o(wdata), .wstrb_o(wstrb), .wready_i(wready),
        .bvalid_i(bvalid), .bready_o(bready),
        .arvalid_o(arvalid), .araddr_o(araddr), .arready_i(arready),
        .rvalid_i(rvalid), .rdata_i(rdata), .rready_o(rready),
        .retire_valid_o(retire_valid), .retire_pc_o(retire_pc),
        .retire_rd_o(retire_rd), .retire_wdata_o(retire_wdata), .halt_o(halt)
    );

    always #50 clk = ~clk;

    assign inst = rom[inst_addr[7:2]];     // combinational fetch port

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            stop_with_failure("a checked value differs from its expected value");
        end
    endtask

    task automatic load_vectors();
        int              fd;
        int              code;
        logic [8*8-1:0]  tag;
        logic [8*96-1:0] rest;
        logic [63:0]     addr;
        logic [31:0]     word;
        for (int i = 0; i < 64; i++) begin
            rom[i] = '0;
        end
        fd = $fopen("verification/core_vectors.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open verification/core_vectors.txt");
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "P") begin
                code = $fscanf(fd, "%h %h", addr, word);
                if (code != 2) begin
                    stop_with_failure("malformed program line in the vector file");
                end
                rom[addr[7:2]] = word;
            end else if (tag == "E") begin
                if (exp_count >= MAX_ENTRIES) begin
                    stop_with_failure("too many expected entries in the vector file");
                end
                code = $fscanf(fd, "%s %h %d %h", exp_name[exp_count], exp_pc[exp_count],
                               exp_rd[exp_count], exp_value[exp_count]);
                if (code != 4) begin
                    stop_with_failure("malformed expected line in the vector file");
                end
                exp_count++;
            end else begin
                code = $fgets(rest, fd);    // comment line
            end
        end
        $fclose(fd);
    endtask

    // axi4-lite memory with random ready and response delays
    always @(posedge clk) begin
        if (!arst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            ar_got  <= 1'b0;
            aw_wait <= $urandom % 4;
            w_wait  <= $urandom % 4;
            ar_wait <= $urandom % 4;
            b_wait  <= $urandom % 4;
            r_wait  <= $urandom % 4;
            for (int k = 0; k < 64; k++) begin
                dmem[k] <= '0;
            end
        end else begin
            if (awvalid && awready) begin
                awready   <= 1'b0;
                aw_got    <= 1'b1;
                aw_addr_q <= awaddr;
                aw_wait   <= $urandom % 4;
            end else if (awvalid && !aw_got) begin
                if (aw_wait == 0) begin
                    awready <= 1'b1;
                end else begin
                    aw_wait <= aw_wait - 1;
                end
            end
            if (wvalid && wready) begin
                check_value("wstrb", 64'hff, {56'b0, wstrb});
                wready   <= 1'b0;
                w_got    <= 1'b1;
                w_data_q <= wdata;
                w_wait   <= $urandom % 4;
            end else if (wvalid && !w_got) begin
                if (w_wait == 0) begin
                    wready <= 1'b1;
                end else begin
                    w_wait <= w_wait - 1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                b_wait <= $urandom % 4;
            end else if (aw_got && w_got && !bvalid) begin
                if (b_wait == 0) begin
                    dmem[aw_addr_q[8:3]] <= w_data_q;  // doubleword index
                    bvalid <= 1'b1;
                    aw_got <= 1'b0;
                    w_got  <= 1'b0;
                end else begin
                    b_wait <= b_wait - 1;
                end
            end
            if (arvalid && arready) begin
                arready   <= 1'b0;
                ar_got    <= 1'b1;
                ar_addr_q <= araddr;
                ar_wait   <= $urandom % 4;
            end else if (arvalid && !ar_got) begin
                if (ar_wait == 0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 1;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                r_wait <= $urandom % 4;
            end else if (ar_got && !rvalid) begin
                if (r_wait == 0) begin
                    rdata  <= dmem[ar_addr_q[8:3]];
                    rvalid <= 1'b1;
                    ar_got <= 1'b0;
                end else begin
                    r_wait <= r_wait - 1;
                end
            end
        end
    end

    // retire trace compared in program order at mid-cycle
    always @(negedge clk) begin
        if (arst_n && retire_valid) begin
            if (retire_count >= exp_count) begin
                stop_with_failure("an instruction retired beyond the expected trace");
            end else begin
                check_value($sformatf("%0s pc", exp_name[retire_count]),
                            exp_pc[retire_count], retire_pc);
                check_value($sformatf("%0s rd", exp_name[retire_count]),
                            {59'b0, exp_rd[retire_count]}, {59'b0, retire_rd});
                if (exp_rd[retire_count] != 5'd0) begin   // no value without a write
                    check_value($sformatf("%0s value", exp_name[retire_count]),
                                exp_value[retire_count], retire_wdata);
                end
                retire_count = retire_count + 1;
            end
        end
    end

    initial begin
        wait (vectors_loaded);
        repeat (RESET_CYCLES + 20 * (exp_count + 1)) @(posedge clk);
        stop_with_failure("timeout: the core did not halt within the cycle budget");
    end

    initial begin
        seed = $urandom(40818);
        load_vectors();
        vectors_loaded = 1'b1;
        arst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        wait (halt === 1'b1);
        @(posedge clk);
        check_value("retire_count_at_halt", 64'(exp_count), 64'(retire_count));
        repeat (HALT_CYCLES) @(posedge clk);
        check_value("halt_held_after_quiet_window", 64'd1, {63'b0, halt});
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/rv_core_top.sv
// instruction port is combinational; data port is an axi4-lite master with one access in flight
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  wire                          clk_i,
    input  wire                          arst_n_i,
    output wire [rv_pkg::XLEN-1:0]       inst_addr_o,
    input  wire [31:0]                   inst_i,
    output wire                          awvalid_o,
    output wire [rv_pkg::XLEN-1:0]       awaddr_o,
    input  wire                          awready_i,
    output wire                          wvalid_o,
    output wire [rv_pkg::XLEN-1:0]       wdata_o,
    output wire [rv_pkg::XLEN/8-1:0]     wstrb_o,
    input  wire                          wready_i,
    input  wire                          bvalid_i,
    output wire                          bready_o,
    output wire                          arvalid_o,
    output wire [rv_pkg::XLEN-1:0]       araddr_o,
    input  wire                          arready_i,
    input  wire                          rvalid_i,
    input  wire [rv_pkg::XLEN-1:0]       rdata_i,
    output wire                          rready_o,
    output wire                          retire_valid_o,
    output wire [rv_pkg::XLEN-1:0]       retire_pc_o,
    output wire [rv_pkg::REG_ADDR_W-1:0] retire_rd_o,
    output wire [rv_pkg::XLEN-1:0]       retire_wdata_o,
    output wire                          halt_o
);

    localparam int XL        = rv_pkg::XLEN;
    localparam int RW        = rv_pkg::REG_ADDR_W;
    localparam int IF_ID_W   = XL + 32;
    localparam int ID_EX_W   = 4 * XL + 3 + RW + 3;
    localparam int EX_MEM_W  = 3 * XL + RW + 3;
    localparam int MEM_WB_W  = 2 * XL + RW + 1;

    wire [XL-1:0]    if_pc, id_pc, ex_pc, mem_pc, wb_pc;
    wire [31:0]      id_inst;
    wire             id_valid, ex_valid, mem_valid, wb_valid;
    wire             id_stall, id_redirect, mem_busy, fetch_hold;
    wire [XL-1:0]    id_redirect_pc, id_src1, id_src2, id_store_data;
    wire [RW-1:0]    rs1_addr, rs2_addr, id_rd, ex_rd, mem_rd, wb_rd;
    wire [XL-1:0]    rs1_data, rs2_data;
    wire             id_is_load, id_is_store, id_is_halt;
    wire             ex_is_load, ex_is_store, ex_is_halt;
    wire             mem_is_load, mem_is_store, mem_is_halt, wb_is_halt;
    wire rv_pkg::alu_op_e id_alu_op;
    wire [2:0]       ex_alu_op_raw;
    wire [XL-1:0]    ex_src1, ex_src2, ex_store_data, ex_result;
    wire [XL-1:0]    mem_alu_result, mem_store_data, mem_result, wb_wdata;

    assign fetch_hold = id_stall || mem_busy;

    if_stage #(.RESET_PC(RESET_PC)) u_if_stage (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .stall_i(fetch_hold), .redirect_i(id_redirect), .redirect_pc_i(id_redirect_pc),
        .halt_i(halt_o), .inst_addr_o(inst_addr_o), .pc_o(if_pc)
    );

    pipe_reg #(.WIDTH(IF_ID_W)) u_if_id (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .stall_i(fetch_hold), .flush_i(id_redirect), .valid_i(1'b1),
        .data_i({if_pc, inst_i}),
        .valid_o(id_valid), .data_o({id_pc, id_inst})
    );

    id_stage u_id_stage (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .valid_i(id_valid), .pc_i(id_pc), .inst_i(id_inst),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .ex_valid_i(ex_valid), .ex_rd_i(ex_rd), .ex_is_load_i(ex_is_load),
        .ex_result_i(ex_result),
        .mem_valid_i(mem_valid), .mem_rd_i(mem_rd), .mem_result_i(mem_result),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .stall_o(id_stall),
        .redirect_o(id_redirect), .redirect_pc_o(id_redirect_pc),
        .alu_op_o(id_alu_op), .src1_o(id_src1), .src2_o(id_src2),
        .store_data_o(id_store_data), .rd_o(id_rd),
        .is_load_o(id_is_load), .is_store_o(id_is_store), .is_halt_o(id_is_halt)
    );

    pipe_reg #(.WIDTH(ID_EX_W)) u_id_ex (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .stall_i(mem_busy), .flush_i(id_stall), .valid_i(id_valid),
        .data_i({id_pc, id_alu_op, id_src1, id_src2, id_store_data, id_rd,
                 id_is_load, id_is_store, id_is_halt}),
        .valid_o(ex_valid),
        .data_o({ex_pc, ex_alu_op_raw, ex_src1, ex_src2, ex_store_data, ex_rd,
                 ex_is_load, ex_is_store, ex_is_halt})
    );

    ex_stage u_ex_stage (
        .alu_op_i(rv_pkg::alu_op_e'(ex_alu_op_raw)),
        .src1_i(ex_src1), .src2_i(ex_src2), .result_o(ex_result)
    );

    pipe_reg #(.WIDTH(EX_MEM_W)) u_ex_mem (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .stall_i(mem_busy), .flush_i(1'b0), .valid_i(ex_valid),
        .data_i({ex_pc, ex_result, ex_store_data, ex_rd, ex_is_load, ex_is_store, ex_is_halt}),
        .valid_o(mem_valid),
        .data_o({mem_pc, mem_alu_result, mem_store_data, mem_rd,
                 mem_is_load, mem_is_store, mem_is_halt})
    );

    mem_stage u_mem_stage (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .valid_i(mem_valid), .is_load_i(mem_is_load), .is_store_i(mem_is_store),
        .addr_i(mem_alu_result), .store_data_i(mem_store_data),
        .alu_result_i(mem_alu_result),
        .awvalid_o(awvalid_o), .awaddr_o(awaddr_o), .awready_i(awready_i),
        .wvalid_o(wvalid_o), .wdata_o(wdata_o), .wstrb_o(wstrb_o), .wready_i(wready_i),
        .bvalid_i(bvalid_i), .bready_o(bready_o),
        .arvalid_o(arvalid_o), .araddr_o(araddr_o), .arready_i(arready_i),
        .rvalid_i(rvalid_i), .rdata_i(rdata_i), .rready_o(rready_o),
        .mem_busy_o(mem_busy), .result_o(mem_result)
    );

    // a frozen memory stage sends bubbles into writeback
    pipe_reg #(.WIDTH(MEM_WB_W)) u_mem_wb (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .stall_i(1'b0), .flush_i(mem_busy), .valid_i(mem_valid),
        .data_i({mem_pc, mem_rd, mem_result, mem_is_halt}),
        .valid_o(wb_valid), .data_o({wb_pc, wb_rd, wb_wdata, wb_is_halt})
    );

    wb_stage u_wb_stage (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .valid_i(wb_valid), .pc_i(wb_pc), .rd_i(wb_rd), .wdata_i(wb_wdata),
        .is_halt_i(wb_is_halt), .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o),
        .retire_rd_o(retire_rd_o), .retire_wdata_o(retire_wdata_o), .halt_o(halt_o)
    );

endmodule

`default_nettype wire

// File: hdl/wb_stage.sv
// x0 is hardwired; nothing writes or retires once ebreak has retired
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
    input  wire                           clk_i,
    input  wire                           arst_n_i,
    input  wire                           valid_i,
    input  wire [rv_pkg::XLEN-1:0]        pc_i,
    input  wire [rv_pkg::REG_ADDR_W-1:0]  rd_i,
    input  wire [rv_pkg::XLEN-1:0]        wdata_i,
    input  wire                           is_halt_i,
    input  wire [rv_pkg::REG_ADDR_W-1:0]  rs1_addr_i,
    input  wire [rv_pkg::REG_ADDR_W-1:0]  rs2_addr_i,
    output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]       rs2_data_o,
    output logic                          retire_valid_o,
    output logic [rv_pkg::XLEN-1:0]       retire_pc_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] retire_rd_o,
    output logic [rv_pkg::XLEN-1:0]       retire_wdata_o,
    output logic                          halt_o
);

    logic [rv_pkg::XLEN-1:0] regs_q [1:31];
    logic                    halt_q;
    logic                    we;

    assign we = valid_i && !halt_q && (rd_i != '0);

    always_ff @(posedge clk_i) begin
        if (we) begin
            regs_q[rd_i] <= wdata_i;
        end
    end

    // write-through so decode sees this cycle's write
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 :
                        (we && rd_i == rs1_addr_i) ? wdata_i : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 :
                        (we && rd_i == rs2_addr_i) ? wdata_i : regs_q[rs2_addr_i];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_valid_o <= 1'b0;
            halt_q         <= 1'b0;
        end else begin
            retire_valid_o <= valid_i && !halt_q;
            if (valid_i && is_halt_i) halt_q <= 1'b1;  // sticky
        end
    end

    always_ff @(posedge clk_i) begin
        retire_pc_o    <= pc_i;
        retire_rd_o    <= rd_i;
        retire_wdata_o <= wdata_i;
    end

    assign halt_o = halt_q;

endmodule

`default_nettype wire

// File: hdl/mem_stage.sv
// one axi4-lite access at a time, full 64-bit strobes, response codes ignored
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire                         clk_i,
    input  wire                         arst_n_i,
    input  wire                         valid_i,
    input  wire                         is_load_i,
    input  wire                         is_store_i,
    input  wire [rv_pkg::XLEN-1:0]      addr_i,
    input  wire [rv_pkg::XLEN-1:0]      store_data_i,
    input  wire [rv_pkg::XLEN-1:0]      alu_result_i,
    output logic                        awvalid_o,
    output logic [rv_pkg::XLEN-1:0]     awaddr_o,
    input  wire                         awready_i,
    output logic                        wvalid_o,
    output logic [rv_pkg::XLEN-1:0]     wdata_o,
    output logic [rv_pkg::XLEN/8-1:0]   wstrb_o,
    input  wire                         wready_i,
    input  wire                         bvalid_i,
    output logic                        bready_o,
    output logic                        arvalid_o,
    output logic [rv_pkg::XLEN-1:0]     araddr_o,
    input  wire                         arready_i,
    input  wire                         rvalid_i,
    input  wire [rv_pkg::XLEN-1:0]      rdata_i,
    output logic                        rready_o,
    output logic                        mem_busy_o,
    output logic [rv_pkg::XLEN-1:0]     result_o
);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_ADDR    = 2'd1;
    localparam logic [1:0] ST_WR_WAIT = 2'd2;
    localparam logic [1:0] ST_RD_WAIT = 2'd3;

    logic [1:0] state_q;
    logic       aw_q, w_q, ar_q;
    logic       access, addr_done, done;

    assign access    = valid_i && (is_load_i || is_store_i);
    assign addr_done = (!aw_q || awready_i) && (!w_q || wready_i) && (!ar_q || arready_i);
    assign done      = (state_q == ST_WR_WAIT && bvalid_i) || (state_q == ST_RD_WAIT && rvalid_i);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
            aw_q    <= 1'b0;
            w_q     <= 1'b0;
            ar_q    <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (access) begin
                        state_q <= ST_ADDR;
                        aw_q    <= is_store_i;  // aw and w go up together
                        w_q     <= is_store_i;
                        ar_q    <= is_load_i;
                    end
                end
                ST_ADDR: begin
                    if (awready_i) aw_q <= 1'b0;
                    if (wready_i) w_q <= 1'b0;
                    if (arready_i) ar_q <= 1'b0;
                    if (addr_done) state_q <= ar_q ? ST_RD_WAIT : ST_WR_WAIT;
                end
                default: begin
                    if (done) state_q <= ST_IDLE;
                end
            endcase
        end
    end

    assign awvalid_o = aw_q;
    assign awaddr_o  = addr_i;      // ex/mem register holds it while busy
    assign wvalid_o  = w_q;
    assign wdata_o   = store_data_i;
    assign wstrb_o   = '1;
    assign arvalid_o = ar_q;
    assign araddr_o  = addr_i;
    assign bready_o  = (state_q == ST_WR_WAIT);
    assign rready_o  = (state_q == ST_RD_WAIT);

    // busy drops in the b/r handshake cycle so the access leaves at the next edge
    assign mem_busy_o = access && !done;
    assign result_o   = is_load_i ? rdata_i : alu_result_i;

    a_aw_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o));

endmodule

`default_nettype wire

// File: hdl/ex_stage.sv
// purely combinational; slt compares signed and there are no shifts
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  wire rv_pkg::alu_op_e    alu_op_i,
    input  wire [rv_pkg::XLEN-1:0]  src1_i,
    input  wire [rv_pkg::XLEN-1:0]  src2_i,
    output logic [rv_pkg::XLEN-1:0] result_o
);

    logic lt;

    assign lt = $signed(src1_i) < $signed(src2_i);

    always_comb begin
        case (alu_op_i)
            rv_pkg::ALU_ADD:    result_o = src1_i + src2_i;     // also ld/sd address
            rv_pkg::ALU_SUB:    result_o = src1_i - src2_i;
            rv_pkg::ALU_AND:    result_o = src1_i & src2_i;
            rv_pkg::ALU_OR:     result_o = src1_i | src2_i;
            rv_pkg::ALU_XOR:    result_o = src1_i ^ src2_i;
            rv_pkg::ALU_SLT:    result_o = {{(rv_pkg::XLEN-1){1'b0}}, lt};
            rv_pkg::ALU_PASS_B: result_o = src2_i;
            default:            result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/id_stage.sv
// only beq/bne and jal redirect; unknown opcodes decode as no-ops that write nothing
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  wire                           clk_i,
    input  wire                           arst_n_i,
    input  wire                           valid_i,
    input  wire [rv_pkg::XLEN-1:0]        pc_i,
    input  wire rv_pkg::rv_inst_u         inst_i,
    input  wire [rv_pkg::XLEN-1:0]        rs1_data_i,
    input  wire [rv_pkg::XLEN-1:0]        rs2_data_i,
    input  wire                           ex_valid_i,
    input  wire [rv_pkg::REG_ADDR_W-1:0]  ex_rd_i,
    input  wire                           ex_is_load_i,
    input  wire [rv_pkg::XLEN-1:0]        ex_result_i,
    input  wire                           mem_valid_i,
    input  wire [rv_pkg::REG_ADDR_W-1:0]  mem_rd_i,
    input  wire [rv_pkg::XLEN-1:0]        mem_result_i,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    output logic                          stall_o,
    output logic                          redirect_o,
    output logic [rv_pkg::XLEN-1:0]       redirect_pc_o,
    output rv_pkg::alu_op_e               alu_op_o,
    output logic [rv_pkg::XLEN-1:0]       src1_o,
    output logic [rv_pkg::XLEN-1:0]       src2_o,
    output logic [rv_pkg::XLEN-1:0]       store_data_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] rd_o,
    output logic                          is_load_o,
    output logic                          is_store_o,
    output logic                          is_halt_o
);

    logic [rv_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;
    logic [rv_pkg::XLEN-1:0] rs1_val, rs2_val;
    logic                    ex_hit1, ex_hit2, mem_hit1, mem_hit2;
    logic                    uses_rs1, uses_rs2, is_branch, is_jal, taken;
    rv_pkg::alu_op_e         alu_f3;

    assign rs1_addr_o = inst_i.r_view.rs1;
    assign rs2_addr_o = inst_i.r_view.rs2;

    // s and b immediates come from the register view, i, j and u from the immediate view
    assign imm_i = {{52{inst_i.i_view.imm[11]}}, inst_i.i_view.imm};
    assign imm_s = {{52{inst_i.r_view.funct7[6]}}, inst_i.r_view.funct7, inst_i.r_view.rd};
    assign imm_b = {{52{inst_i.r_view.funct7[6]}}, inst_i.r_view.rd[0],
                    inst_i.r_view.funct7[5:0], inst_i.r_view.rd[4:1], 1'b0};
    assign imm_j = {{44{inst_i.i_view.imm[11]}}, inst_i.i_view.rs1, inst_i.i_view.funct3,
                    inst_i.i_view.imm[0], inst_i.i_view.imm[10:1], 1'b0};
    assign imm_u = {{32{inst_i.i_view.imm[11]}}, inst_i.i_view.imm, inst_i.i_view.rs1,
                    inst_i.i_view.funct3, 12'b0};

    // nearest producer wins; rd is zero for anything that writes nothing
    assign ex_hit1  = ex_valid_i && (ex_rd_i != '0) && (ex_rd_i == rs1_addr_o);
    assign ex_hit2  = ex_valid_i && (ex_rd_i != '0) && (ex_rd_i == rs2_addr_o);
    assign mem_hit1 = mem_valid_i && (mem_rd_i != '0) && (mem_rd_i == rs1_addr_o);
    assign mem_hit2 = mem_valid_i && (mem_rd_i != '0) && (mem_rd_i == rs2_addr_o);
    assign rs1_val  = ex_hit1 ? ex_result_i : mem_hit1 ? mem_result_i : rs1_data_i;
    assign rs2_val  = ex_hit2 ? ex_result_i : mem_hit2 ? mem_result_i : rs2_data_i;

    always_comb begin
        case (inst_i.r_view.funct3)
            3'b111:  alu_f3 = rv_pkg::ALU_AND;
            3'b110:  alu_f3 = rv_pkg::ALU_OR;
            3'b100:  alu_f3 = rv_pkg::ALU_XOR;
            3'b010:  alu_f3 = rv_pkg::ALU_SLT;
            default: alu_f3 = rv_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        alu_op_o     = rv_pkg::ALU_ADD;
        src1_o       = rs1_val;
        src2_o       = rs2_val;
        store_data_o = rs2_val;
        rd_o         = '0;
        is_load_o    = 1'b0;
        is_store_o   = 1'b0;
        is_halt_o    = 1'b0;
        uses_rs1     = 1'b0;
        uses_rs2     = 1'b0;
        is_branch    = 1'b0;
        is_jal       = 1'b0;
        case (inst_i.r_view.opcode)
            rv_pkg::OPC_OP: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                rd_o     = inst_i.r_view.rd;
                alu_op_o = (inst_i.r_view.funct3 == 3'b000 && inst_i.r_view.funct7[5]) ?
                           rv_pkg::ALU_SUB : alu_f3;
            end
            rv_pkg::OPC_OP_IMM: begin
                uses_rs1 = 1'b1;
                rd_o     = inst_i.i_view.rd;
                alu_op_o = alu_f3;
                src2_o   = imm_i;
            end
            rv_pkg::OPC_LUI: begin
                rd_o     = inst_i.i_view.rd;
                alu_op_o = rv_pkg::ALU_PASS_B;
                src2_o   = imm_u;
            end
            rv_pkg::OPC_LOAD: begin
                uses_rs1  = 1'b1;
                rd_o      = inst_i.i_view.rd;
                src2_o    = imm_i;              // alu forms the address
                is_load_o = 1'b1;
            end
            rv_pkg::OPC_STORE: begin
                uses_rs1   = 1'b1;
                uses_rs2   = 1'b1;
                src2_o     = imm_s;
                is_store_o = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                is_branch = 1'b1;
            end
            rv_pkg::OPC_JAL: begin
                is_jal   = 1'b1;
                rd_o     = inst_i.i_view.rd;
                alu_op_o = rv_pkg::ALU_PASS_B;
                src2_o   = pc_i + rv_pkg::XLEN'(4);  // link value
            end
            rv_pkg::OPC_SYSTEM: is_halt_o = (inst_i.i_view.imm == 12'd1);  // ebreak
            default: ;
        endcase
    end

    assign taken         = inst_i.r_view.funct3[0] ? (rs1_val != rs2_val) : (rs1_val == rs2_val);
    assign stall_o       = valid_i && ex_is_load_i && ((ex_hit1 && uses_rs1) || (ex_hit2 && uses_rs2));
    assign redirect_o    = valid_i && !stall_o && (is_jal || (is_branch && taken));
    assign redirect_pc_o = pc_i + (is_jal ? imm_j : imm_b);

    // the slot behind a redirect is squashed unless the front end is frozen
    a_redirect_squashes: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) redirect_o |=> !valid_i || $stable(pc_i));

endmodule

`default_nettype wire

// File: hdl/if_stage.sv
// fetch has no valid output; the instruction port must answer in the same cycle
`timescale 1ns/1ps
`default_nettype none

module if_stage #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  wire                     clk_i,
    input  wire                     arst_n_i,
    input  wire                     stall_i,
    input  wire                     redirect_i,
    input  wire [rv_pkg::XLEN-1:0]  redirect_pc_i,
    input  wire                     halt_i,
    output logic [rv_pkg::XLEN-1:0] inst_addr_o,
    output logic [rv_pkg::XLEN-1:0] pc_o
);

    logic [rv_pkg::XLEN-1:0] pc_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else if (!(stall_i || halt_i)) begin
            pc_q <= redirect_i ? redirect_pc_i : pc_q + rv_pkg::XLEN'(4);
        end
    end

    assign inst_addr_o = pc_q;
    assign pc_o        = pc_q;      // same cycle as the fetch

    // decode must see only bubbles while reset is applied
    a_no_redirect_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !redirect_i);

endmodule

`default_nettype wire

// File: hdl/pipe_reg.sv
// stall wins over flush; the payload is not reset, only the valid bit is
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter int WIDTH = 32
) (
    input  wire              clk_i,
    input  wire              arst_n_i,
    input  wire              stall_i,
    input  wire              flush_i,
    input  wire              valid_i,
    input  wire [WIDTH-1:0]  data_i,
    output logic             valid_o,
    output logic [WIDTH-1:0] data_o
);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
        end else if (!stall_i) begin
            valid_o <= valid_i && !flush_i;     // flush leaves a bubble
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            data_o <= data_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rv_pkg.sv
// rv64i subset only; the enum and union below assume the standard 32-bit base encoding
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B      // result is operand b, used by lui and jal
    } alu_op_e;

    // one instruction word, seen as register form or immediate form
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_view;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
    } rv_inst_u;

endpackage

`default_nettype wire
